/* Bender.yml */
package:
  name: mem_io
  authors: []

sources:
  - source/mem_io_pkg.sv
  - source/req_router.sv
  - source/bram_bank.sv
  - source/io_reg_bank.sv
  - source/resp_merge.sv
  - source/mem_io_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/mem_io_tb.sv

/* bench/mem_io_tb.sv */
// testbench for mem_io_top, replays bench/mem_tests.txt and checks every tagged response
`timescale 1ns/100ps

module mem_io_tb;

   localparam int          FIELDS    = 9;
   localparam int          MAX_TESTS = 64;
   localparam int          LATENCY   = 3;
   localparam logic [15:0] LFSR_SEED = 16'd22429;
   localparam logic [15:0] LFSR_TAPS = 16'hb400;

   logic                  mig_clk;
   logic                  arst_n_i;
   logic                  req_valid_i;
   logic                  req_write_i;
   mem_io_pkg::paddr_t    req_addr_i;
   mem_io_pkg::line_t     req_wdata_i;
   mem_io_pkg::strb_t     req_strb_i;
   mem_io_pkg::tag_t      req_tag_i;
   logic                  resp_valid_o;
   mem_io_pkg::resp_tag_t resp_tag_o;
   mem_io_pkg::resp_t     resp_code_o;
   mem_io_pkg::line_t     resp_rdata_o;

   // nine words per test in the column order of the data file
   logic [127:0] vectors [0:MAX_TESTS*FIELDS-1];

   int          num_tests   = 0;
   int          cycle       = 0;
   int          cycle_limit = 0;
   bit          limit_set   = 1'b0;
   int          error_count = 0;
   int          done_count  = 0;
   int          pass_count  = 0;
   logic [15:0] lfsr        = LFSR_SEED;

   // expected responses in request order
   mem_io_pkg::resp_tag_t exp_tag_q  [$];
   mem_io_pkg::resp_t     exp_code_q [$];
   mem_io_pkg::line_t     exp_data_q [$];
   int                    stamp_q    [$];
   int                    index_q    [$];

   tb_clock_gen #(
      .PERIOD       ( 4.0 ),
      .RESET_CYCLES ( 2   )
   ) clock_gen_inst (
      .clk_o    ( mig_clk  ),
      .arst_n_o ( arst_n_i )
   );

   mem_io_top #(
      .BRAM_ADDR_WIDTH ( 16 ),
      .IO_REG_COUNT    ( 8  )
   ) mem_io_top_inst (
      .mig_clk      ( mig_clk      ),
      .arst_n_i     ( arst_n_i     ),
      .req_valid_i  ( req_valid_i  ),
      .req_write_i  ( req_write_i  ),
      .req_addr_i   ( req_addr_i   ),
      .req_wdata_i  ( req_wdata_i  ),
      .req_strb_i   ( req_strb_i   ),
      .req_tag_i    ( req_tag_i    ),
      .resp_valid_o ( resp_valid_o ),
      .resp_tag_o   ( resp_tag_o   ),
      .resp_code_o  ( resp_code_o  ),
      .resp_rdata_o ( resp_rdata_o )
   );

   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ LFSR_TAPS;
      end else begin
         return state >> 1;
      end
   endfunction

   // one lfsr step per bit
   task automatic random_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         value = (value << 1) | lfsr[0];
         lfsr  = lfsr_next(lfsr);
      end
   endtask

   task automatic check_tag(input mem_io_pkg::resp_tag_t got, input mem_io_pkg::resp_tag_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t resp_tag_o got %h expected %h", $time, got, exp);
         error_count++;
      end
   endtask

   task automatic check_code(input mem_io_pkg::resp_t got, input mem_io_pkg::resp_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t resp_code_o got %0d expected %0d", $time, got, exp);
         error_count++;
      end
   endtask

   task automatic check_line(input mem_io_pkg::line_t got, input mem_io_pkg::line_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t resp_rdata_o got %h expected %h", $time, got, exp);
         error_count++;
      end
   endtask

   task automatic check_latency(input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] %0t latency got %0d expected %0d", $time, got, exp);
         error_count++;
      end
   endtask

   task automatic drive_request(input int t);
      int base;
      base        = t * FIELDS;
      req_write_i = vectors[base][0];
      req_addr_i  = mem_io_pkg::paddr_t'(vectors[base+1]);
      req_strb_i  = mem_io_pkg::strb_t'(vectors[base+2]);
      req_wdata_i = vectors[base+3];
      req_tag_i   = mem_io_pkg::tag_t'(vectors[base+4]);
      req_valid_i = 1'b1;
      exp_tag_q.push_back(mem_io_pkg::resp_tag_t'(vectors[base+5]));
      exp_code_q.push_back(mem_io_pkg::resp_t'(vectors[base+6]));
      exp_data_q.push_back(vectors[base+7]);
      stamp_q.push_back(cycle);
      index_q.push_back(t);
   endtask

   task automatic take_response();
      int idx;
      int stamp;
      int errors_before;
      if (exp_tag_q.size() == 0) begin
         $display("%0t response seen with no request outstanding", $time);
         error_count++;
      end else begin
         errors_before = error_count;
         idx           = index_q.pop_front();
         stamp         = stamp_q.pop_front();
         check_tag(resp_tag_o, exp_tag_q.pop_front());
         check_code(resp_code_o, exp_code_q.pop_front());
         check_line(resp_rdata_o, exp_data_q.pop_front());
         check_latency(cycle - stamp, LATENCY);
         done_count++;
         if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d tag %h passed", idx, resp_tag_o);
         end else begin
            $display("test %0d tag %h failed", idx, resp_tag_o);
         end
      end
   endtask

   always @(posedge mig_clk) begin
      cycle <= cycle + 1;
   end

   // outputs are stable around the falling edge
   initial begin
      forever begin
         @(negedge mig_clk);
         if (arst_n_i === 1'b1) begin
            if (resp_valid_o === 1'b1) begin
               take_response();
            end else if (resp_valid_o !== 1'b0) begin
               $display("%0t resp_valid_o is unknown after reset", $time);
               error_count++;
            end
         end
      end
   end

   initial begin
      wait (limit_set);
      while (cycle < cycle_limit) begin
         @(posedge mig_clk);
      end
      $display("timeout after %0d cycles with %0d responses still missing",
               cycle, exp_tag_q.size());
      $display("sim failed");
      $finish;
   end

   initial begin
      int gap;
      req_valid_i = 1'b0;
      req_write_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_strb_i  = '0;
      req_tag_i   = '0;

      $readmemh("bench/mem_tests.txt", vectors);
      while (num_tests < MAX_TESTS && !$isunknown(vectors[num_tests*FIELDS])) begin
         num_tests++;
      end
      if (num_tests == 0) begin
         $display("no tests found in bench/mem_tests.txt");
         error_count++;
      end
      cycle_limit = num_tests * 7 + 50;
      limit_set   = 1'b1;

      wait (arst_n_i === 1'b1);
      @(negedge mig_clk);
      for (int t = 0; t < num_tests; t++) begin
         // burst column forces a zero gap
         if (vectors[t*FIELDS+8][0]) begin
            gap = 0;
         end else begin
            random_bits(2, gap);
         end
         repeat (gap) @(negedge mig_clk);
         drive_request(t);
         @(negedge mig_clk);
         req_valid_i = 1'b0;
      end

      while (exp_tag_q.size() != 0) begin
         @(negedge mig_clk);
      end
      // catch stray responses
      repeat (LATENCY + 1) @(negedge mig_clk);

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               num_tests, pass_count, done_count - pass_count, error_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* bench/mem_tests.txt */
// columns: write addr strb wdata tag, then exp_tag exp_code exp_rdata, then burst
// all hex, burst 1 means no idle cycles before the request
// line write, strobed partial write, read back through an unaligned address
1 00000010 ffff 00112233445566778899aabbccddeeff 01 01 0 0 0
1 00000010 0f0f a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 02 02 0 0 0
0 0000001c 0000 0 03 03 0 00112233a5a5a5a58899aabba5a5a5a5 0
// io register write, strobed write with high lanes set, reads
1 80000008 ffff 0123456789abcdeffedcba9876543210 04 24 0 0 0
1 80000008 ff0f ffffffffffffffff3333333333333333 05 25 0 0 0
0 80000008 0000 0 06 26 0 0000000000000000fedcba9833333333 0
0 80000000 0000 0 07 27 0 0 0
// unmapped accesses, the line behind 00010010 alias stays unchanged
0 40000000 0000 0 08 08 3 0 0
1 00010010 ffff ffffffffffffffffffffffffffffffff 09 09 3 0 0
1 80000040 ffff ffffffffffffffffffffffffffffffff 0a 0a 3 0 0
0 00000010 0000 0 0b 0b 0 00112233a5a5a5a58899aabba5a5a5a5 0
// back to back mix of memory, io and errors
1 00000020 ffff 0f0e0d0c0b0a09080706050403020100 10 10 0 0 0
1 80000038 00ff 00000000000000000123456789abcdef 11 31 0 0 1
0 ffff0000 0000 0 12 12 3 0 1
0 00000020 0000 0 13 13 0 0f0e0d0c0b0a09080706050403020100 1
0 80000038 0000 0 14 34 0 00000000000000000123456789abcdef 1
0 00000010 0000 0 15 15 0 00112233a5a5a5a58899aabba5a5a5a5 1
0 80000008 0000 0 16 36 0 0000000000000000fedcba9833333333 1
1 00000020 8001 11111111111111111111111111111111 17 17 0 0 1
0 00000020 0000 0 18 18 0 110e0d0c0b0a09080706050403020111 1
0 80000000 0000 0 1f 3f 0 0 1
0 00000010 0000 0 1f 1f 0 00112233a5a5a5a58899aabba5a5a5a5 1
// last line of block RAM
1 0000fff0 ffff 8899aabbccddeeff0011223344556677 1c 1c 0 0 0
0 0000ffff 0000 0 1d 1d 0 8899aabbccddeeff0011223344556677 1
0 00010000 0000 0 1e 1e 3 0 1

/* bench/tb_clock_gen.sv */
// bench clock source, drives mig_clk and holds the asynchronous reset low at start
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter real PERIOD       = 4.0,
   parameter int  RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2.0) clk_o = ~clk_o;
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      arst_n_o = 1'b0;
      #(PERIOD * RESET_CYCLES);
      arst_n_o = 1'b1;
   end

endmodule

/* source/bram_bank.sv */
// on-chip block RAM of 128-bit lines with byte write enables and a delayed-address read
`timescale 1ns/100ps

module bram_bank #(
   parameter int BRAM_ADDR_WIDTH = 16,
   localparam int LINE_IDX_W     = BRAM_ADDR_WIDTH - mem_io_pkg::LINE_OFFSET,
   localparam int LINE_COUNT     = 2 ** LINE_IDX_W
) (
   input  logic                  mig_clk,
   input  logic                  sel_i,
   input  logic                  wr_i,
   input  logic [LINE_IDX_W-1:0] line_i,
   input  mem_io_pkg::line_t     wdata_i,
   input  mem_io_pkg::strb_t     strb_i,
   output mem_io_pkg::line_t     rdata_o
);

   // contents undefined until written
   mem_io_pkg::line_t     ram [0:LINE_COUNT-1];
   logic [LINE_IDX_W-1:0] line_dly;

   always_ff @(posedge mig_clk) begin
      if (sel_i) begin
         line_dly <= line_i;
         if (wr_i) begin
            foreach (strb_i[i]) begin
               if (strb_i[i]) begin
                  ram[line_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
               end
            end
         end
      end
   end

   // address held from the last select, so the line reads out a cycle later
   assign rdata_o = ram[line_dly];

endmodule

/* source/io_reg_bank.sv */
// small bank of 64-bit IO registers with byte-strobed writes and a registered read
`timescale 1ns/100ps

module io_reg_bank #(
   parameter int IO_REG_COUNT = 8,
   localparam int IO_IDX_W    = (IO_REG_COUNT > 1) ? $clog2(IO_REG_COUNT) : 1
) (
   input  logic                 mig_clk,
   input  logic                 arst_n_i,
   input  logic                 sel_i,
   input  logic                 wr_i,
   input  logic [IO_IDX_W-1:0]  index_i,
   input  mem_io_pkg::io_word_t wdata_i,
   input  logic [7:0]           strb_i,
   output mem_io_pkg::io_word_t rdata_o
);

   mem_io_pkg::io_word_t regs [0:IO_REG_COUNT-1];

   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int r = 0; r < IO_REG_COUNT; r++) begin
            regs[r] <= '0;
         end
      end else if (sel_i && wr_i) begin
         for (int b = 0; b < 8; b++) begin
            if (strb_i[b]) begin
               regs[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
      end
   end

   // read data held until the next select
   always_ff @(posedge mig_clk) begin
      if (sel_i) begin
         rdata_o <= regs[index_i];
      end
   end

endmodule

/* source/mem_io_pkg.sv */
// shared widths, address map and response codes for the memory/IO request path
package mem_io_pkg;

   // data path widths
   localparam int MEM_DAT_WIDTH = 128;
   localparam int IO_DAT_WIDTH  = 64;
   localparam int PADDR_WIDTH   = 32;

   // requester tag, widened by one bit on the response side
   localparam int MEM_TAG_WIDTH = 5;

   typedef logic [PADDR_WIDTH-1:0]     paddr_t;
   typedef logic [MEM_DAT_WIDTH-1:0]   line_t;
   typedef logic [MEM_DAT_WIDTH/8-1:0] strb_t;
   typedef logic [IO_DAT_WIDTH-1:0]    io_word_t;
   typedef logic [MEM_TAG_WIDTH-1:0]   tag_t;

   // top bit set for IO, clear for memory
   typedef logic [MEM_TAG_WIDTH:0]     resp_tag_t;

   typedef logic [1:0]                 resp_t;

   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_DECERR = 2'd3;

   // address map
   localparam paddr_t BRAM_BASE = 32'h0000_0000;
   localparam paddr_t IO_BASE   = 32'h8000_0000;

   // io window is 4 KB
   localparam int IO_SPAN_BITS = 12;

   // 16 bytes per memory line
   localparam int LINE_OFFSET = $clog2(MEM_DAT_WIDTH/8);

endpackage

/* source/mem_io_top.sv */
// top level of the memory/IO request path, joins router, banks and response merger
`timescale 1ns/100ps

module mem_io_top #(
   parameter int BRAM_ADDR_WIDTH = 16,
   parameter int IO_REG_COUNT    = 8
) (
   input  logic                  mig_clk,
   input  logic                  arst_n_i,
   input  logic                  req_valid_i,
   input  logic                  req_write_i,
   input  mem_io_pkg::paddr_t    req_addr_i,
   input  mem_io_pkg::line_t     req_wdata_i,
   input  mem_io_pkg::strb_t     req_strb_i,
   input  mem_io_pkg::tag_t      req_tag_i,
   output logic                  resp_valid_o,
   output mem_io_pkg::resp_tag_t resp_tag_o,
   output mem_io_pkg::resp_t     resp_code_o,
   output mem_io_pkg::line_t     resp_rdata_o
);

   localparam int LINE_IDX_W = BRAM_ADDR_WIDTH - mem_io_pkg::LINE_OFFSET;
   localparam int IO_IDX_W   = (IO_REG_COUNT > 1) ? $clog2(IO_REG_COUNT) : 1;

   // router outputs
   logic                  bram_sel;
   logic [LINE_IDX_W-1:0] bram_line;
   logic                  io_sel;
   logic [IO_IDX_W-1:0]   io_index;
   logic                  wr;
   mem_io_pkg::line_t     wdata;
   mem_io_pkg::strb_t     strb;
   logic                  stage_valid;
   mem_io_pkg::tag_t      tag;
   logic                  is_io;
   logic                  dec_err;

   // bank results
   mem_io_pkg::line_t     bram_rdata;
   mem_io_pkg::io_word_t  io_rdata;

   req_router #(
      .BRAM_ADDR_WIDTH ( BRAM_ADDR_WIDTH ),
      .IO_REG_COUNT    ( IO_REG_COUNT    )
   ) req_router_inst (
      .mig_clk       ( mig_clk     ),
      .arst_n_i      ( arst_n_i    ),
      .req_valid_i   ( req_valid_i ),
      .req_write_i   ( req_write_i ),
      .req_addr_i    ( req_addr_i  ),
      .req_wdata_i   ( req_wdata_i ),
      .req_strb_i    ( req_strb_i  ),
      .req_tag_i     ( req_tag_i   ),
      .bram_sel_o    ( bram_sel    ),
      .bram_line_o   ( bram_line   ),
      .io_sel_o      ( io_sel      ),
      .io_index_o    ( io_index    ),
      .wr_o          ( wr          ),
      .wdata_o       ( wdata       ),
      .strb_o        ( strb        ),
      .stage_valid_o ( stage_valid ),
      .tag_o         ( tag         ),
      .is_io_o       ( is_io       ),
      .dec_err_o     ( dec_err     )
   );

   bram_bank #(
      .BRAM_ADDR_WIDTH ( BRAM_ADDR_WIDTH )
   ) bram_bank_inst (
      .mig_clk ( mig_clk    ),
      .sel_i   ( bram_sel   ),
      .wr_i    ( wr         ),
      .line_i  ( bram_line  ),
      .wdata_i ( wdata      ),
      .strb_i  ( strb       ),
      .rdata_o ( bram_rdata )
   );

   // io side sees only the low word and low byte lanes
   io_reg_bank #(
      .IO_REG_COUNT ( IO_REG_COUNT )
   ) io_reg_bank_inst (
      .mig_clk  ( mig_clk                               ),
      .arst_n_i ( arst_n_i                              ),
      .sel_i    ( io_sel                                ),
      .wr_i     ( wr                                    ),
      .index_i  ( io_index                              ),
      .wdata_i  ( wdata[mem_io_pkg::IO_DAT_WIDTH-1:0]   ),
      .strb_i   ( strb[7:0]                             ),
      .rdata_o  ( io_rdata                              )
   );

   resp_merge resp_merge_inst (
      .mig_clk       ( mig_clk      ),
      .arst_n_i      ( arst_n_i     ),
      .stage_valid_i ( stage_valid  ),
      .tag_i         ( tag          ),
      .wr_i          ( wr           ),
      .is_io_i       ( is_io        ),
      .dec_err_i     ( dec_err      ),
      .bram_rdata_i  ( bram_rdata   ),
      .io_rdata_i    ( io_rdata     ),
      .resp_valid_o  ( resp_valid_o ),
      .resp_tag_o    ( resp_tag_o   ),
      .resp_code_o   ( resp_code_o  ),
      .resp_rdata_o  ( resp_rdata_o )
   );

endmodule

/* source/req_router.sv */
// registers each incoming request and decodes its address into bram, io or error strobes
`timescale 1ns/100ps

module req_router #(
   parameter int BRAM_ADDR_WIDTH = 16,
   parameter int IO_REG_COUNT    = 8,
   localparam int LINE_IDX_W     = BRAM_ADDR_WIDTH - mem_io_pkg::LINE_OFFSET,
   localparam int IO_IDX_W       = (IO_REG_COUNT > 1) ? $clog2(IO_REG_COUNT) : 1
) (
   input  logic                     mig_clk,
   input  logic                     arst_n_i,
   input  logic                     req_valid_i,
   input  logic                     req_write_i,
   input  mem_io_pkg::paddr_t       req_addr_i,
   input  mem_io_pkg::line_t        req_wdata_i,
   input  mem_io_pkg::strb_t        req_strb_i,
   input  mem_io_pkg::tag_t         req_tag_i,
   output logic                     bram_sel_o,
   output logic [LINE_IDX_W-1:0]    bram_line_o,
   output logic                     io_sel_o,
   output logic [IO_IDX_W-1:0]      io_index_o,
   output logic                     wr_o,
   output mem_io_pkg::line_t        wdata_o,
   output mem_io_pkg::strb_t        strb_o,
   output logic                     stage_valid_o,
   output mem_io_pkg::tag_t         tag_o,
   output logic                     is_io_o,
   output logic                     dec_err_o
);

   localparam int IO_BYTES = 8 * IO_REG_COUNT;

   mem_io_pkg::paddr_t                   bram_off;
   logic [mem_io_pkg::IO_SPAN_BITS-1:0] io_off;
   logic                                in_bram;
   logic                                in_io;
   logic [LINE_IDX_W-1:0]               line_idx;
   logic [IO_IDX_W-1:0]                 io_idx;

   // region decode, the only place addresses are tested
   always_comb begin
      bram_off = req_addr_i - mem_io_pkg::BRAM_BASE;
      io_off   = req_addr_i[mem_io_pkg::IO_SPAN_BITS-1:0];

      in_bram = (req_addr_i >= mem_io_pkg::BRAM_BASE) &&
                ((bram_off >> BRAM_ADDR_WIDTH) == '0);

      in_io = ((req_addr_i >> mem_io_pkg::IO_SPAN_BITS) ==
               (mem_io_pkg::IO_BASE >> mem_io_pkg::IO_SPAN_BITS)) &&
              (io_off < IO_BYTES);

      line_idx = bram_off[mem_io_pkg::LINE_OFFSET +: LINE_IDX_W];
      // one 64-bit register per 8 bytes
      io_idx   = io_off[3 +: IO_IDX_W];
   end

   // control stage
   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stage_valid_o <= 1'b0;
         bram_sel_o    <= 1'b0;
         io_sel_o      <= 1'b0;
         wr_o          <= 1'b0;
         is_io_o       <= 1'b0;
         dec_err_o     <= 1'b0;
      end else begin
         stage_valid_o <= req_valid_i;
         bram_sel_o    <= req_valid_i && in_bram;
         io_sel_o      <= req_valid_i && in_io;
         wr_o          <= req_write_i;
         is_io_o       <= in_io;
         // unmapped, no bank sees it
         dec_err_o     <= req_valid_i && !in_bram && !in_io;
      end
   end

   // request payload
   always_ff @(posedge mig_clk) begin
      bram_line_o <= line_idx;
      io_index_o  <= io_idx;
      wdata_o     <= req_wdata_i;
      strb_o      <= req_strb_i;
      tag_o       <= req_tag_i;
   end

endmodule

/* source/resp_merge.sv */
// lines up request info with bank results and registers one tagged response per request
`timescale 1ns/100ps

module resp_merge (
   input  logic                  mig_clk,
   input  logic                  arst_n_i,
   input  logic                  stage_valid_i,
   input  mem_io_pkg::tag_t      tag_i,
   input  logic                  wr_i,
   input  logic                  is_io_i,
   input  logic                  dec_err_i,
   input  mem_io_pkg::line_t     bram_rdata_i,
   input  mem_io_pkg::io_word_t  io_rdata_i,
   output logic                  resp_valid_o,
   output mem_io_pkg::resp_tag_t resp_tag_o,
   output mem_io_pkg::resp_t     resp_code_o,
   output mem_io_pkg::line_t     resp_rdata_o
);

   logic              dly_valid;
   mem_io_pkg::tag_t  dly_tag;
   logic              dly_wr;
   logic              dly_io;
   logic              dly_err;
   mem_io_pkg::line_t rdata_sel;

   // one stage behind the router, level with the bank outputs
   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dly_valid <= 1'b0;
         dly_wr    <= 1'b0;
         dly_io    <= 1'b0;
         dly_err   <= 1'b0;
      end else begin
         dly_valid <= stage_valid_i;
         dly_wr    <= wr_i;
         dly_io    <= is_io_i;
         dly_err   <= dec_err_i;
      end
   end

   always_ff @(posedge mig_clk) begin
      dly_tag <= tag_i;
   end

   // writes and errors answer with zero data
   always_comb begin
      if (dly_wr || dly_err) begin
         rdata_sel = '0;
      end else if (dly_io) begin
         rdata_sel = {{(mem_io_pkg::MEM_DAT_WIDTH-mem_io_pkg::IO_DAT_WIDTH){1'b0}}, io_rdata_i};
      end else begin
         rdata_sel = bram_rdata_i;
      end
   end

   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= dly_valid;
      end
   end

   // response payload
   always_ff @(posedge mig_clk) begin
      resp_tag_o   <= {dly_io, dly_tag};
      resp_code_o  <= dly_err ? mem_io_pkg::RESP_DECERR : mem_io_pkg::RESP_OKAY;
      resp_rdata_o <= rdata_sel;
   end

endmodule

/* vlog.f */
source/mem_io_pkg.sv
source/req_router.sv
source/bram_bank.sv
source/io_reg_bank.sv
source/resp_merge.sv
source/mem_io_top.sv
bench/tb_clock_gen.sv
bench/mem_io_tb.sv
